// ==== audio_pkg.sv ====
// shared audio types and rates; hold lengths are shortened for simulation
`default_nettype none

package audio_pkg;

	// sample format
	localparam int audio_dw = 16;

	// clock and frame rates
	localparam int sys_clk_hz = 27_000_000;
	localparam int sample_rate_hz = 48_000;

	// two channels, two sclk phases per bit
	localparam int sclk_phase_rate = sample_rate_hz * 2 * audio_dw * 2;

	// accumulator must hold sys_clk_hz plus one step
	localparam int acc_w = $clog2(sys_clk_hz + sclk_phase_rate);

	// reset hold lengths in clk cycles
	localparam int poweron_hold = 64;
	localparam int request_hold = 16;
	localparam int hold_w = $clog2(poweron_hold + 1);

	// bit position inside a channel word, counts 1..audio_dw
	typedef logic [4:0] bit_idx_t;

	typedef struct packed {
		logic [audio_dw-1:0] left;
		logic [audio_dw-1:0] right;
	} sample_pair_t;

	typedef struct packed {
		logic sclk;
		logic lrclk;
		logic sdata;
	} i2s_bus_t;

	// idle only between reset and the first falling sclk
	typedef enum logic [1:0] {
		st_idle,
		st_left,
		st_right
	} frame_state_t;

endpackage

`default_nettype wire

// ==== reset_sequencer.sv ====
// core_reset is synchronous to clk; pll_locked low clears everything at once
`timescale 1ns/1ns
`default_nettype none

module reset_sequencer (
	input  logic clk,
	input  logic pll_locked,
	input  logic reset_request,
	output logic core_reset
);
	import audio_pkg::*;

	logic [hold_w-1:0] hold_cnt;

	always_ff @(posedge clk or negedge pll_locked) begin
		if (!pll_locked) begin
			hold_cnt <= hold_w'(poweron_hold);
			core_reset <= 1'b1;
		end else begin
			// a request only ever lengthens the hold
			if (reset_request && (hold_w'(request_hold) > hold_cnt))
				hold_cnt <= hold_w'(request_hold);
			else if (hold_cnt != '0)
				hold_cnt <= hold_cnt - 1'b1;

			// request strobe itself counts as the first reset cycle
			core_reset <= (hold_cnt != '0) || reset_request;
		end
	end

	// counter and output must never disagree
	a_hold_means_reset: assert property (
		@(posedge clk) disable iff (!pll_locked)
		(hold_cnt != '0) |-> core_reset
	);

endmodule

`default_nettype wire

// ==== i2s_rate_timer.sv ====
// phase_ce averages sclk_phase_rate; gaps jitter between 8 and 9 clk cycles
`timescale 1ns/1ns
`default_nettype none

module i2s_rate_timer (
	input  logic clk,
	input  logic pll_locked,
	input  logic core_reset,
	output logic phase_ce
);
	import audio_pkg::*;

	logic [acc_w-1:0] acc;
	logic [acc_w-1:0] acc_sum;

	assign acc_sum = acc + acc_w'(sclk_phase_rate);

	always_ff @(posedge clk or negedge pll_locked) begin
		if (!pll_locked) begin
			acc <= '0;
			phase_ce <= 1'b0;
		end else if (core_reset) begin
			acc <= '0;
			phase_ce <= 1'b0;
		end else begin
			phase_ce <= 1'b0;
			acc <= acc_sum;
			// wrap and fire one phase step
			if (acc_sum >= acc_w'(sys_clk_hz)) begin
				acc <= acc_sum - acc_w'(sys_clk_hz);
				phase_ce <= 1'b1;
			end
		end
	end

	// downstream edge logic relies on the rate ratio keeping pulses apart
	a_ce_single: assert property (
		@(posedge clk) disable iff (!pll_locked)
		phase_ce |=> !phase_ce
	);

endmodule

`default_nettype wire

// ==== i2s_frame_fsm.sv ====
// MSB-first framing; lrclk changes with the first bit, no one-bit I2S delay
`timescale 1ns/1ns
`default_nettype none

module i2s_frame_fsm (
	input  logic                clk,
	input  logic                pll_locked,
	input  logic                core_reset,
	input  logic                phase_ce,
	output logic                sclk,
	output logic                lrclk,
	output logic                frame_start,
	output audio_pkg::bit_idx_t bit_idx
);
	import audio_pkg::*;

	frame_state_t state;
	logic last_bit;

	assign last_bit = (bit_idx == bit_idx_t'(audio_dw));

	always_ff @(posedge clk or negedge pll_locked) begin
		if (!pll_locked) begin
			state <= st_idle;
			sclk <= 1'b1;
			lrclk <= 1'b1;
			bit_idx <= bit_idx_t'(1);
			frame_start <= 1'b0;
		end else if (core_reset) begin
			state <= st_idle;
			sclk <= 1'b1;
			lrclk <= 1'b1;
			bit_idx <= bit_idx_t'(1);
			frame_start <= 1'b0;
		end else begin
			frame_start <= 1'b0;
			if (phase_ce) begin
				sclk <= ~sclk;
				// everything moves on the high-to-low phase
				if (sclk) begin
					if (state == st_idle || (state == st_right && last_bit)) begin
						state <= st_left;
						lrclk <= 1'b0;
						bit_idx <= bit_idx_t'(1);
						frame_start <= 1'b1;
					end else if (last_bit) begin
						state <= st_right;
						lrclk <= 1'b1;
						bit_idx <= bit_idx_t'(1);
					end else begin
						bit_idx <= bit_idx + 1'b1;
					end
				end
			end
		end
	end

	// serializer indexes the word with audio_dw - bit_idx
	a_bit_idx_range: assert property (
		@(posedge clk) disable iff (!pll_locked)
		(bit_idx >= bit_idx_t'(1)) && (bit_idx <= bit_idx_t'(audio_dw))
	);

endmodule

`default_nettype wire

// ==== i2s_serializer.sv ====
// bus lags the FSM by one clk; a pair not latched at frame start is lost
`timescale 1ns/1ns
`default_nettype none

module i2s_serializer (
	input  logic                    clk,
	input  logic                    pll_locked,
	input  logic                    core_reset,
	input  logic                    sample_valid,
	input  logic                    sclk,
	input  logic                    lrclk,
	input  logic                    frame_start,
	input  audio_pkg::sample_pair_t sample_in,
	input  audio_pkg::bit_idx_t     bit_idx,
	output audio_pkg::i2s_bus_t     i2s
);
	import audio_pkg::*;

	sample_pair_t hold_pair;
	sample_pair_t frame_pair;
	sample_pair_t cur_pair;
	logic [audio_dw-1:0] chan_word;
	logic sclk_q;
	logic lrclk_q;
	logic sdata;
	logic sclk_fall;

	assign sclk_fall = sclk_q & ~sclk;

	// first bit of a frame comes straight from the holding register
	assign cur_pair = frame_start ? hold_pair : frame_pair;
	assign chan_word = lrclk ? cur_pair.right : cur_pair.left;

	always_ff @(posedge clk) begin
		if (sample_valid)
			hold_pair <= sample_in;
		if (frame_start)
			frame_pair <= hold_pair;
	end

	always_ff @(posedge clk or negedge pll_locked) begin
		if (!pll_locked) begin
			sclk_q <= 1'b1;
			lrclk_q <= 1'b1;
			sdata <= 1'b1;
		end else if (core_reset) begin
			sclk_q <= 1'b1;
			lrclk_q <= 1'b1;
			sdata <= 1'b1;
		end else begin
			sclk_q <= sclk;
			lrclk_q <= lrclk;
			if (sclk_fall)
				sdata <= chan_word[audio_dw - int'(bit_idx)];
		end
	end

	assign i2s = '{sclk: sclk_q, lrclk: lrclk_q, sdata: sdata};

	// FSM is held idle during reset, so no frame may start then
	a_no_frame_in_reset: assert property (
		@(posedge clk) disable iff (!pll_locked)
		!(frame_start && core_reset)
	);

endmodule

`default_nettype wire

// ==== audio_out_top.sv ====
// single clock domain; sample_valid has no back-pressure and the last pair repeats
`timescale 1ns/1ns
`default_nettype none

module audio_out_top (
	input  logic                    clk,
	input  logic                    pll_locked,
	input  logic                    reset_request,
	input  logic                    sample_valid,
	input  audio_pkg::sample_pair_t sample_in,
	output logic                    core_reset,
	output audio_pkg::i2s_bus_t     i2s
);
	import audio_pkg::*;

	logic phase_ce;
	logic sclk;
	logic lrclk;
	logic frame_start;
	bit_idx_t bit_idx;

	reset_sequencer u_reset_seq (
		.clk           (clk),
		.pll_locked    (pll_locked),
		.reset_request (reset_request),
		.core_reset    (core_reset)
	);

	// bit clock phase enable
	i2s_rate_timer u_rate_timer (
		.clk        (clk),
		.pll_locked (pll_locked),
		.core_reset (core_reset),
		.phase_ce   (phase_ce)
	);

	i2s_frame_fsm u_frame_fsm (
		.clk         (clk),
		.pll_locked  (pll_locked),
		.core_reset  (core_reset),
		.phase_ce    (phase_ce),
		.sclk        (sclk),
		.lrclk       (lrclk),
		.frame_start (frame_start),
		.bit_idx     (bit_idx)
	);

	i2s_serializer u_serializer (
		.clk          (clk),
		.pll_locked   (pll_locked),
		.core_reset   (core_reset),
		.sample_valid (sample_valid),
		.sclk         (sclk),
		.lrclk        (lrclk),
		.frame_start  (frame_start),
		.sample_in    (sample_in),
		.bit_idx      (bit_idx),
		.i2s          (i2s)
	);

endmodule

`default_nettype wire

// ==== tb_audio_out.sv ====
// expects the bus one clk behind the frame FSM; inputs change on the falling clk edge
`timescale 1ns/1ns
`default_nettype none

module tb_audio_out;
	import audio_pkg::*;

	localparam int frame_count = 14;
	localparam int request_frame = 6;
	localparam int frame_timeout = 2000;
	localparam int reset_timeout = 200;
	// clk cycles between sclk edges follow the rate ratio
	localparam int gap_min = sys_clk_hz / sclk_phase_rate;
	localparam int gap_max = gap_min + 1;
	localparam i2s_bus_t bus_idle = '{sclk: 1'b1, lrclk: 1'b1, sdata: 1'b1};

	logic clk;
	logic pll_locked;
	logic reset_request;
	logic sample_valid;
	sample_pair_t sample_in;
	logic core_reset;
	i2s_bus_t i2s;

	int seed;

	// receiver model
	i2s_bus_t prev_bus;
	logic [audio_dw-1:0] left_word;
	logic [audio_dw-1:0] right_word;
	int left_bits;
	int right_bits;
	logic frame_open;
	sample_pair_t frame_expected;
	sample_pair_t hold_model;
	int frames_seen;
	int frames_checked;
	int gap_cycles;
	logic gap_valid;

	audio_out_top dut0 (
		.clk           (clk),
		.pll_locked    (pll_locked),
		.reset_request (reset_request),
		.sample_valid  (sample_valid),
		.sample_in     (sample_in),
		.core_reset    (core_reset),
		.i2s           (i2s)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic report_mismatch(input string msg);
		$display("mismatch at %0t ns: %s", $time, msg);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic report_failure(input string msg);
		$display("error at %0t ns: %s", $time, msg);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check_pair(input sample_pair_t exp, input sample_pair_t act, input string what);
		if (act !== exp)
			report_mismatch($sformatf("%s: got L=%h R=%h, expected L=%h R=%h",
				what, act.left, act.right, exp.left, exp.right));
	endtask

	task automatic check_bus(input i2s_bus_t exp, input i2s_bus_t act, input string what);
		if (act !== exp)
			report_mismatch($sformatf("%s: bus %b, expected %b", what, act, exp));
	endtask

	task automatic check_count(input int exp, input int act, input string what);
		if (act != exp)
			report_mismatch($sformatf("%s: got %0d, expected %0d", what, act, exp));
	endtask

	// lrclk fell, so the previous frame is complete
	task automatic close_frame();
		sample_pair_t got;
		if (frame_open) begin
			check_count(audio_dw, left_bits, "left bits in frame");
			check_count(audio_dw, right_bits, "right bits in frame");
			got.left = left_word;
			got.right = right_word;
			check_pair(frame_expected, got, "received frame");
			frames_checked++;
		end
		// new frame carries the holding register as it stands now
		frame_expected = hold_model;
		frame_open = 1'b1;
		left_bits = 0;
		right_bits = 0;
		frames_seen++;
	endtask

	// one clk cycle of bus monitoring
	task automatic sample_cycle();
		i2s_bus_t cur;
		@(negedge clk);
		cur = i2s;
		if (core_reset) begin
			frame_open = 1'b0;
			left_bits = 0;
			right_bits = 0;
			gap_valid = 1'b0;
			gap_cycles = 0;
		end else begin
			gap_cycles++;
			if (cur.sclk != prev_bus.sclk) begin
				if (gap_valid && (gap_cycles < gap_min || gap_cycles > gap_max))
					report_mismatch($sformatf("sclk edge after %0d clk cycles", gap_cycles));
				gap_cycles = 0;
				gap_valid = 1'b1;
			end
			if (cur.lrclk != prev_bus.lrclk && !(prev_bus.sclk && !cur.sclk))
				report_mismatch("lrclk changed away from a falling sclk edge");
			// capture MSB first on rising sclk
			if (!prev_bus.sclk && cur.sclk) begin
				if (cur.lrclk) begin
					right_word = {right_word[audio_dw-2:0], cur.sdata};
					right_bits++;
				end else begin
					left_word = {left_word[audio_dw-2:0], cur.sdata};
					left_bits++;
				end
			end
			if (prev_bus.lrclk && !cur.lrclk)
				close_frame();
		end
		prev_bus = cur;
	endtask

	task automatic wait_frame_start();
		int start;
		int waited;
		start = frames_seen;
		waited = 0;
		while (frames_seen == start) begin
			if (waited == frame_timeout)
				report_failure("no lrclk fall came within the frame timeout");
			sample_cycle();
			waited++;
		end
	endtask

	task automatic strobe_pair(input sample_pair_t pair);
		sample_in = pair;
		sample_valid = 1'b1;
		hold_model = pair;
		sample_cycle();
		sample_valid = 1'b0;
	endtask

	task automatic request_reset();
		int idle;
		int cnt;
		idle = 20 + ($unsigned($random(seed)) % 280);
		repeat (idle) sample_cycle();
		check_count(0, int'(core_reset), "core_reset before request");
		reset_request = 1'b1;
		sample_cycle();
		reset_request = 1'b0;
		cnt = 0;
		while (core_reset) begin
			cnt++;
			// bus goes idle one clk after core_reset
			if (cnt > 1)
				check_bus(bus_idle, i2s, "bus during requested reset");
			if (cnt > reset_timeout)
				report_failure("core_reset stayed high after a reset request");
			sample_cycle();
		end
		check_bus(bus_idle, i2s, "bus after requested reset");
		check_count(request_hold + 1, cnt, "requested core_reset cycles");
	endtask

	initial begin
		int cnt;
		int delay;
		int skips;
		logic skip;
		sample_pair_t pair;
		seed = 32'h772f_c1ea;
		pll_locked = 1'b0;
		reset_request = 1'b0;
		sample_valid = 1'b0;
		sample_in = '0;
		prev_bus = bus_idle;
		left_word = '0;
		right_word = '0;
		left_bits = 0;
		right_bits = 0;
		frame_open = 1'b0;
		frame_expected = '0;
		hold_model = '0;
		frames_seen = 0;
		frames_checked = 0;
		gap_cycles = 0;
		gap_valid = 1'b0;
		skips = 0;

		repeat (3) begin
			sample_cycle();
			check_bus(bus_idle, i2s, "bus while pll unlocked");
		end

		// power-on hold
		pll_locked = 1'b1;
		cnt = 0;
		while (core_reset) begin
			check_bus(bus_idle, i2s, "bus during power-on hold");
			if (cnt == reset_timeout)
				report_failure("core_reset never fell after pll lock");
			sample_cycle();
			cnt++;
		end
		check_bus(bus_idle, i2s, "bus at end of power-on hold");
		check_count(poweron_hold + 1, cnt, "power-on core_reset cycles");

		pair = $random(seed);
		strobe_pair(pair);

		for (int f = 0; f < frame_count; f++) begin
			wait_frame_start();
			delay = 2 + ($random(seed) & 3);
			repeat (delay) sample_cycle();
			skip = (f % 5 == 3) || (($random(seed) & 7) == 0);
			if (skip) begin
				skips++;
			end else begin
				pair = $random(seed);
				strobe_pair(pair);
			end
			if (f == request_frame)
				request_reset();
		end
		// closes the last frame
		wait_frame_start();

		if (frames_checked >= frame_count - 2) begin
			$display("Simulation passed");
			$finish;
		end else begin
			report_failure($sformatf("only %0d frames checked, %0d skipped",
				frames_checked, skips));
		end
	end

endmodule

`default_nettype wire

// ==== sources.f ====
audio_pkg.sv
reset_sequencer.sv
i2s_rate_timer.sv
i2s_frame_fsm.sv
i2s_serializer.sv
audio_out_top.sv
tb_audio_out.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -j 0 \
	--top-module tb_audio_out -f sources.f

# the log decides the result, not the exit status of the run
./obj_dir/Vtb_audio_out 2>&1 | tee sim.log

if grep -qx "Simulation passed" sim.log; then
	echo "PASS"
	exit 0
else
	echo "FAIL"
	exit 1
fi
